/* hw/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // Cluster shape
    localparam int NUM_HARTS  = 4;                // CSR files in the cluster
    localparam int HART_W     = 2;                // Hart select width
    localparam int XLEN       = 32;               // CSR word width
    localparam int CNT_W      = 64;               // Cycle and instret counters
    localparam int CSR_ADDR_W = 12;               // CSR address width
    localparam int CSR_CMD_W  = 3;                // Command code width
    localparam int PRIV_W     = 2;                // Privilege code width

    // Command codes
    localparam logic [CSR_CMD_W-1:0] CSR_CMD_NONE       = 3'd0;
    localparam logic [CSR_CMD_W-1:0] CSR_CMD_WRITE      = 3'd1;
    localparam logic [CSR_CMD_W-1:0] CSR_CMD_READ       = 3'd2;
    localparam logic [CSR_CMD_W-1:0] CSR_CMD_READ_WRITE = 3'd3;
    localparam logic [CSR_CMD_W-1:0] CSR_CMD_MRET       = 3'd4;

    // Privilege levels, 2 is reserved
    localparam logic [PRIV_W-1:0] PRIV_USER       = 2'd0;
    localparam logic [PRIV_W-1:0] PRIV_SUPERVISOR = 2'd1;
    localparam logic [PRIV_W-1:0] PRIV_MACHINE    = 2'd3;

    // Identity words
    localparam logic [XLEN-1:0] CSR_MVENDORID = 32'h0A1A_A1E0;
    localparam logic [XLEN-1:0] CSR_MARCHID   = 32'h0000_0001;
    localparam logic [XLEN-1:0] CSR_MIMPID    = 32'h0000_0001;
    localparam logic [XLEN-1:0] CSR_MISA_BASE = 32'h4014_1100; // RV32 I M S U, A bit clear

    // Machine CSRs
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MTVAL     = 12'h343;
    // Supervisor CSRs
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_STVEC     = 12'h105;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_SSCRATCH  = 12'h140;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_SEPC      = 12'h141;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_SCAUSE    = 12'h142;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_STVAL     = 12'h143;
    // Counters, writable halves
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_CYCLE     = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_INSTRET   = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_CYCLEH    = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_INSTRETH  = 12'hB82;
    // Read-only words
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MHARTID   = 12'hF14;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MCURPRIV  = 12'hFC0; // Current privilege

endpackage

`default_nettype wire

/* hw/csr_dispatch.sv */
`default_nettype none

module csr_dispatch import csr_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    req,          // Four-phase request
    input  wire [HART_W-1:0]       hart_sel,
    input  wire [CSR_CMD_W-1:0]    cmd,
    input  wire [CSR_ADDR_W-1:0]   address,
    input  wire [XLEN-1:0]         writedata,
    input  wire                    ack,          // From collector
    output logic [NUM_HARTS-1:0]   strobe,       // One-hot, one cycle
    output logic [CSR_CMD_W-1:0]   cmd_q,
    output logic [CSR_ADDR_W-1:0]  address_q,
    output logic [XLEN-1:0]        writedata_q,
    output logic [HART_W-1:0]      hart_q,
    output logic                   done          // Collector capture pulse
);

    typedef enum logic {
        ST_IDLE,                                 // Waiting for a fresh req
        ST_ISSUE                                 // Strobe cycle
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   wait_q;                              // Req still high from last command
    logic   wait_d;
    logic   capture;

    // Fresh request only, never while the previous handshake is open
    assign capture = (state_q == ST_IDLE) && req && !ack && !wait_q;

    always_comb begin
        state_d = state_q;
        wait_d  = wait_q;
        case (state_q)
            ST_IDLE: begin
                if (capture)
                    state_d = ST_ISSUE;
                if (!req)
                    wait_d = 1'b0;               // Ack falls on this same edge
            end
            ST_ISSUE: begin
                state_d = ST_IDLE;               // Single strobe per command
                wait_d  = 1'b1;                  // Hold off until req drops
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            wait_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            wait_q  <= wait_d;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin                       // Command register
            cmd_q       <= cmd;
            address_q   <= address;
            writedata_q <= writedata;
            hart_q      <= hart_sel;
        end
    end

    assign done   = (state_q == ST_ISSUE);
    assign strobe = done ? ({{(NUM_HARTS-1){1'b0}}, 1'b1} << hart_q) : '0;

endmodule

`default_nettype wire

/* hw/csr_file.sv */
`default_nettype none

module csr_file import csr_pkg::*; #(
    parameter int unsigned HART_ID = 0           // Read back through mhartid
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    strobe,       // Commit enable for this hart
    input  wire [CSR_CMD_W-1:0]    cmd,
    input  wire [CSR_ADDR_W-1:0]   address,
    input  wire [XLEN-1:0]         writedata,
    input  wire                    instret_incr,
    output logic [XLEN-1:0]        rd_data,
    output logic                   rd_invalid,
    output logic [PRIV_W-1:0]      privilege
);

    typedef struct packed {
        logic [PRIV_W-1:0] priv;                 // Current privilege
        logic [5:0]        mst_ctl;              // tsr tw tvm mxr sum mprv, bits 22:17
        logic [1:0]        mpp;
        logic              spp;
        logic              mpie;
        logic              spie;
        logic              mie;
        logic              sie;
        logic              misa_a;               // Atomic emulation flag
        logic [XLEN-1:0]   mtvec;
        logic [XLEN-1:0]   stvec;
        logic [XLEN-1:0]   mepc;
        logic [XLEN-1:0]   sepc;
        logic [XLEN-1:0]   mscratch;
        logic [XLEN-1:0]   sscratch;
        logic [XLEN-1:0]   mcause;
        logic [XLEN-1:0]   scause;
        logic [XLEN-1:0]   mtval;
        logic [XLEN-1:0]   stval;
        logic [CNT_W-1:0]  cycle;
        logic [CNT_W-1:0]  instret;
    } csr_state_t;

    csr_state_t      st_q;
    csr_state_t      st_d;
    logic            csr_write;
    logic            csr_read;
    logic            access_invalid;             // Privilege below address[9:8]
    logic            write_invalid;              // Write to read-only space
    logic            wr_ok;
    logic            aligned;
    logic            do_mret;
    logic [XLEN-1:0] mstatus_rd;
    logic [XLEN-1:0] misa_rd;

    assign csr_write      = (cmd == CSR_CMD_WRITE) || (cmd == CSR_CMD_READ_WRITE);
    assign csr_read       = (cmd == CSR_CMD_READ) || (cmd == CSR_CMD_READ_WRITE);
    assign access_invalid = (csr_write || csr_read) && (st_q.priv < address[9:8]);
    assign write_invalid  = csr_write && (address[11:10] == 2'b11);
    assign wr_ok          = strobe && csr_write && !access_invalid;
    assign aligned        = (writedata[1:0] == 2'b00); // Vector and epc rule
    assign do_mret        = strobe && (cmd == CSR_CMD_MRET);

    assign mstatus_rd = {
        9'h0,                                    // SD and reserved
        st_q.mst_ctl,                            // 22:17
        4'h0,                                    // xs, fs
        st_q.mpp,                                // 12:11
        2'b00,
        st_q.spp,                                // 8
        st_q.mpie, 1'b0,
        st_q.spie, 1'b0,
        st_q.mie,  1'b0,
        st_q.sie,  1'b0
    };
    assign misa_rd = {CSR_MISA_BASE[XLEN-1:1], st_q.misa_a};

    always_comb begin
        st_d         = st_q;
        st_d.cycle   = st_q.cycle + CNT_W'(1);   // Free running
        st_d.instret = st_q.instret + CNT_W'(instret_incr);
        rd_data      = '0;
        rd_invalid   = access_invalid;           // Writable CSRs only check level
        case (address)
            CSR_ADDR_MCURPRIV: begin
                rd_data    = XLEN'(st_q.priv);
                rd_invalid = access_invalid || write_invalid;
            end
            CSR_ADDR_MVENDORID: begin
                rd_data    = CSR_MVENDORID;
                rd_invalid = access_invalid || write_invalid;
            end
            CSR_ADDR_MARCHID: begin
                rd_data    = CSR_MARCHID;
                rd_invalid = access_invalid || write_invalid;
            end
            CSR_ADDR_MIMPID: begin
                rd_data    = CSR_MIMPID;
                rd_invalid = access_invalid || write_invalid;
            end
            CSR_ADDR_MHARTID: begin
                rd_data    = XLEN'(HART_ID);
                rd_invalid = access_invalid || write_invalid;
            end
            CSR_ADDR_MSTATUS: begin
                rd_data = mstatus_rd;
                if (wr_ok) begin                 // Implemented fields only
                    st_d.mst_ctl = writedata[22:17];
                    if (writedata[12:11] != 2'b10)
                        st_d.mpp = writedata[12:11]; // Reserved mpp dropped
                    st_d.spp  = writedata[8];
                    st_d.mpie = writedata[7];
                    st_d.spie = writedata[5];
                    st_d.mie  = writedata[3];
                    st_d.sie  = writedata[1];
                end
            end
            CSR_ADDR_MISA: begin
                rd_data = misa_rd;
                if (wr_ok)
                    st_d.misa_a = writedata[0];  // Only the A bit sticks
            end
            CSR_ADDR_MTVEC: begin
                rd_data = st_q.mtvec;
                if (wr_ok && aligned)
                    st_d.mtvec = writedata;
            end
            CSR_ADDR_MEPC: begin
                rd_data = st_q.mepc;
                if (wr_ok && aligned)
                    st_d.mepc = writedata;
            end
            CSR_ADDR_MSCRATCH: begin
                rd_data = st_q.mscratch;
                if (wr_ok)
                    st_d.mscratch = writedata;
            end
            CSR_ADDR_MCAUSE: begin
                rd_data = st_q.mcause;
                if (wr_ok)
                    st_d.mcause = writedata;
            end
            CSR_ADDR_MTVAL: begin
                rd_data = st_q.mtval;
                if (wr_ok)
                    st_d.mtval = writedata;
            end
            CSR_ADDR_STVEC: begin
                rd_data = st_q.stvec;
                if (wr_ok && aligned)
                    st_d.stvec = writedata;
            end
            CSR_ADDR_SEPC: begin
                rd_data = st_q.sepc;
                if (wr_ok && aligned)
                    st_d.sepc = writedata;
            end
            CSR_ADDR_SSCRATCH: begin
                rd_data = st_q.sscratch;
                if (wr_ok)
                    st_d.sscratch = writedata;
            end
            CSR_ADDR_SCAUSE: begin
                rd_data = st_q.scause;
                if (wr_ok)
                    st_d.scause = writedata;
            end
            CSR_ADDR_STVAL: begin
                rd_data = st_q.stval;
                if (wr_ok)
                    st_d.stval = writedata;
            end
            CSR_ADDR_CYCLE: begin
                rd_data = st_q.cycle[31:0];
                if (wr_ok)
                    st_d.cycle[31:0] = writedata; // Write beats the increment
            end
            CSR_ADDR_CYCLEH: begin
                rd_data = st_q.cycle[63:32];
                if (wr_ok)
                    st_d.cycle[63:32] = writedata;
            end
            CSR_ADDR_INSTRET: begin
                rd_data = st_q.instret[31:0];
                if (wr_ok)
                    st_d.instret[31:0] = writedata;
            end
            CSR_ADDR_INSTRETH: begin
                rd_data = st_q.instret[63:32];
                if (wr_ok)
                    st_d.instret[63:32] = writedata;
            end
            default: rd_invalid = csr_read || csr_write; // Unknown address
        endcase
        if (do_mret) begin                       // Return to mpp
            st_d.priv = st_q.mpp;
            st_d.mie  = st_q.mpie;
            st_d.mpie = 1'b1;
            st_d.mpp  = PRIV_USER;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_q      <= '0;                     // All CSRs clear
            st_q.priv <= PRIV_MACHINE;           // Boot in machine mode
        end else begin
            st_q <= st_d;
        end
    end

    assign privilege = st_q.priv;

endmodule

`default_nettype wire

/* hw/csr_collect.sv */
`default_nettype none

module csr_collect import csr_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req,             // Watched for the release
    input  wire                        done,            // Strobe cycle of dispatcher
    input  wire [HART_W-1:0]           hart_q,          // Hart of the open command
    input  wire [NUM_HARTS*XLEN-1:0]   rd_data_all,     // Hart 0 in the low word
    input  wire [NUM_HARTS-1:0]        rd_invalid_all,
    output logic                       ack,
    output logic [XLEN-1:0]            readdata,
    output logic                       invalid
);

    logic [XLEN-1:0] sel_data;
    logic            sel_invalid;

    // Response of the addressed hart, before its state updates
    assign sel_data    = rd_data_all[hart_q*XLEN +: XLEN];
    assign sel_invalid = rd_invalid_all[hart_q];

    // Ack rises after the strobe cycle and drops once req is seen low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (done) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    // Response held stable for the rest of the handshake
    always_ff @(posedge clk) begin
        if (done) begin
            readdata <= sel_data;
            invalid  <= sel_invalid;
        end
    end

endmodule

`default_nettype wire

/* hw/csr_cluster.sv */
`default_nettype none

module csr_cluster import csr_pkg::*; (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          req,          // Four-phase request
    input  wire [HART_W-1:0]             hart_sel,
    input  wire [CSR_CMD_W-1:0]          cmd,
    input  wire [CSR_ADDR_W-1:0]         address,
    input  wire [XLEN-1:0]               writedata,
    input  wire [NUM_HARTS-1:0]          instret_incr, // One per hart
    output logic                         ack,
    output logic                         invalid,
    output logic [XLEN-1:0]              readdata,
    output logic [NUM_HARTS*PRIV_W-1:0]  privilege     // Hart 0 in the low bits
);

    logic [NUM_HARTS-1:0]       strobe;
    logic [CSR_CMD_W-1:0]       cmd_q;
    logic [CSR_ADDR_W-1:0]      address_q;
    logic [XLEN-1:0]            writedata_q;
    logic [HART_W-1:0]          hart_q;
    logic                       done;
    logic [NUM_HARTS*XLEN-1:0]  rd_data_all;
    logic [NUM_HARTS-1:0]       rd_invalid_all;

    csr_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .hart_sel    (hart_sel),
        .cmd         (cmd),
        .address     (address),
        .writedata   (writedata),
        .ack         (ack),
        .strobe      (strobe),
        .cmd_q       (cmd_q),
        .address_q   (address_q),
        .writedata_q (writedata_q),
        .hart_q      (hart_q),
        .done        (done)
    );

    // Command fans out to every hart, only the strobed one commits
    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
        csr_file #(
            .HART_ID (h)
        ) u_file (
            .clk          (clk),
            .rst_n        (rst_n),
            .strobe       (strobe[h]),
            .cmd          (cmd_q),
            .address      (address_q),
            .writedata    (writedata_q),
            .instret_incr (instret_incr[h]),
            .rd_data      (rd_data_all[h*XLEN +: XLEN]),
            .rd_invalid   (rd_invalid_all[h]),
            .privilege    (privilege[h*PRIV_W +: PRIV_W])
        );
    end

    csr_collect u_collect (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .done           (done),
        .hart_q         (hart_q),
        .rd_data_all    (rd_data_all),
        .rd_invalid_all (rd_invalid_all),
        .ack            (ack),
        .readdata       (readdata),
        .invalid        (invalid)
    );

endmodule

`default_nettype wire

/* testbench/csr_cluster_asserts.sv */
`default_nettype none

module csr_cluster_asserts import csr_pkg::*; (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  req,
    input wire                  ack,
    input wire                  invalid,
    input wire [XLEN-1:0]       readdata,
    input wire [NUM_HARTS-1:0]  strobe,
    input wire [CSR_CMD_W-1:0]  cmd_q,      // Registered command of the open handshake
    input wire [CSR_ADDR_W-1:0] address_q
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;                   // Summed into the closing line
    logic wr_cmd;
    logic rd_cmd;

    assign wr_cmd = (cmd_q == CSR_CMD_WRITE) || (cmd_q == CSR_CMD_READ_WRITE);
    assign rd_cmd = (cmd_q == CSR_CMD_READ) || (cmd_q == CSR_CMD_READ_WRITE);

    ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> ##2 $rose(ack))
    else begin
        fail_count = fail_count + 1;
        $error("ack did not rise exactly two edges after a fresh req");
    end

    // Rise is seen one edge late, req may already be released by then
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
    else begin
        fail_count = fail_count + 1;
        $error("ack rose while req was low");
    end

    // One hart strobed for a single cycle per fresh req
    strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |=> $onehot(strobe) ##1 (strobe == '0))
    else begin
        fail_count = fail_count + 1;
        $error("strobe was not a single one-hot cycle after a fresh req");
    end

    // Reserved mpp value seen through a valid mstatus read
    mpp_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && !invalid && rd_cmd && (address_q == CSR_ADDR_MSTATUS)) |->
        (readdata[12:11] != 2'b10))
    else begin
        fail_count = fail_count + 1;
        $error("mstatus reports the reserved mpp value");
    end

    ro_write_invalid: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(ack) && wr_cmd && (address_q[11:10] == 2'b11)) |-> invalid)
    else begin
        fail_count = fail_count + 1;
        $error("write to read-only CSR space was not flagged invalid");
    end

endmodule

bind csr_cluster csr_cluster_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .invalid   (invalid),
    .readdata  (readdata),
    .strobe    (strobe),
    .cmd_q     (cmd_q),
    .address_q (address_q)
);

`default_nettype wire

/* testbench/tb_csr_cluster.sv */
`default_nettype none

module tb_csr_cluster import csr_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h007E_19AA;  // Implemented mstatus fields
    localparam logic [CSR_ADDR_W-1:0] PLAIN_ADDR [10] = '{
        CSR_ADDR_MTVEC, CSR_ADDR_MEPC, CSR_ADDR_MSCRATCH, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL,
        CSR_ADDR_STVEC, CSR_ADDR_SEPC, CSR_ADDR_SSCRATCH, CSR_ADDR_SCAUSE, CSR_ADDR_STVAL
    };

    logic                        clk;
    logic                        rst_n;
    logic                        req;
    logic [HART_W-1:0]           hart_sel;
    logic [CSR_CMD_W-1:0]        cmd;
    logic [CSR_ADDR_W-1:0]       address;
    logic [XLEN-1:0]             writedata;
    logic [NUM_HARTS-1:0]        instret_incr;
    logic                        ack;
    logic                        invalid;
    logic [XLEN-1:0]             readdata;
    logic [NUM_HARTS*PRIV_W-1:0] privilege;
    logic [31:0]                 lfsr = 32'd82231;   // Random write data source
    int                          errors = 0;

    // Reference model, plain registers indexed by address bits 9, 6 and 2:0
    logic [XLEN-1:0]   m_reg     [NUM_HARTS][32];
    logic [XLEN-1:0]   m_mstatus [NUM_HARTS];
    logic [PRIV_W-1:0] m_priv    [NUM_HARTS];
    logic [CNT_W-1:0]  m_instret [NUM_HARTS];
    logic              m_misa_a  [NUM_HARTS];

    csr_cluster dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .hart_sel     (hart_sel),
        .cmd          (cmd),
        .address      (address),
        .writedata    (writedata),
        .instret_incr (instret_incr),
        .ack          (ack),
        .invalid      (invalid),
        .readdata     (readdata),
        .privilege    (privilege)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic [XLEN-1:0] random_word();
        logic [XLEN-1:0] w;
        int              b;
        w = '0;
        for (b = 0; b < XLEN; b++) begin
            lfsr = lfsr_step(lfsr);                 // One step per bit
            w = {w[XLEN-2:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic is_plain(input logic [CSR_ADDR_W-1:0] a);
        return a inside {CSR_ADDR_MTVEC, CSR_ADDR_MEPC, CSR_ADDR_MSCRATCH, CSR_ADDR_MCAUSE,
                         CSR_ADDR_MTVAL, CSR_ADDR_STVEC, CSR_ADDR_SEPC, CSR_ADDR_SSCRATCH,
                         CSR_ADDR_SCAUSE, CSR_ADDR_STVAL};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("Errors: %0d from model checks, %0d from assertions",
                 errors, dut0.u_asserts.fail_count);
        if (errors == 0 && dut0.u_asserts.fail_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    endtask

    // Expected response from the pre-command state, then the state update
    task automatic model_apply(input int h, input logic [CSR_CMD_W-1:0] c,
            input logic [CSR_ADDR_W-1:0] a, input logic [XLEN-1:0] wd,
            output logic [XLEN-1:0] exp_data, output logic exp_inv);
        logic            is_wr;
        logic            is_rd;
        logic            known;
        logic [4:0]      slot;
        logic [XLEN-1:0] nw;
        is_wr = (c == CSR_CMD_WRITE) || (c == CSR_CMD_READ_WRITE);
        is_rd = (c == CSR_CMD_READ) || (c == CSR_CMD_READ_WRITE);
        slot  = {a[9], a[6], a[2:0]};
        known = 1'b1;
        case (a)
            CSR_ADDR_MVENDORID: exp_data = CSR_MVENDORID;
            CSR_ADDR_MARCHID:   exp_data = CSR_MARCHID;
            CSR_ADDR_MIMPID:    exp_data = CSR_MIMPID;
            CSR_ADDR_MHARTID:   exp_data = XLEN'(h);
            CSR_ADDR_MCURPRIV:  exp_data = XLEN'(m_priv[h]);
            CSR_ADDR_MSTATUS:   exp_data = m_mstatus[h];
            CSR_ADDR_MISA:      exp_data = {CSR_MISA_BASE[XLEN-1:1], m_misa_a[h]};
            CSR_ADDR_INSTRET:   exp_data = m_instret[h][31:0];
            CSR_ADDR_INSTRETH:  exp_data = m_instret[h][63:32];
            default: begin
                known    = is_plain(a);
                exp_data = known ? m_reg[h][slot] : '0;
            end
        endcase
        // Unknown, too little privilege, or a write into the read-only quarter
        exp_inv = (is_wr || is_rd) &&
                  (!known || (m_priv[h] < a[9:8]) || (is_wr && a[11:10] == 2'b11));
        if (is_wr && !exp_inv) begin
            nw = wd;
            if (a == CSR_ADDR_MSTATUS) begin
                if (nw[12:11] == 2'b10)
                    nw[12:11] = m_mstatus[h][12:11];   // Reserved mpp keeps old
                m_mstatus[h] = nw & MSTATUS_MASK;
            end else if (a == CSR_ADDR_MISA) begin
                m_misa_a[h] = nw[0];
            end else if (a == CSR_ADDR_INSTRET) begin
                m_instret[h][31:0] = nw;
            end else if (a == CSR_ADDR_INSTRETH) begin
                m_instret[h][63:32] = nw;
            end else if (is_plain(a)) begin
                if (nw[1:0] == 2'b00 || !(a inside {CSR_ADDR_MTVEC, CSR_ADDR_STVEC,
                                                    CSR_ADDR_MEPC, CSR_ADDR_SEPC}))
                    m_reg[h][slot] = nw;             // Vectors and epc need alignment
            end
        end
        if (c == CSR_CMD_MRET) begin
            m_priv[h]           = m_mstatus[h][12:11];
            m_mstatus[h][3]     = m_mstatus[h][7];   // mie from mpie
            m_mstatus[h][7]     = 1'b1;
            m_mstatus[h][12:11] = PRIV_USER;
        end
    endtask

    // One four-phase handshake, req held for extra cycles after ack
    task automatic run_cmd(input int h, input logic [CSR_CMD_W-1:0] c,
            input logic [CSR_ADDR_W-1:0] a, input logic [XLEN-1:0] wd, input int hold = 0);
        logic [XLEN-1:0] exp_data;
        logic            exp_inv;
        int              cnt;
        int              i;
        @(posedge clk);
        #1;
        hart_sel  = HART_W'(h);
        cmd       = c;
        address   = a;
        writedata = wd;
        req       = 1'b1;
        cnt = 0;
        while (!ack && cnt < 50) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!ack) begin
            errors++;
            $display("Timeout: hart %0d gave no ack within 50 cycles", h);
            end_run();
        end else begin
            model_apply(h, c, a, wd, exp_data, exp_inv);
            check_equal("invalid", 32'(invalid), 32'(exp_inv));
            if ((c == CSR_CMD_READ || c == CSR_CMD_READ_WRITE) && !exp_inv)
                check_equal("readdata", readdata, exp_data);
            for (i = 0; i < NUM_HARTS; i++)
                check_equal("privilege", 32'(privilege[i*PRIV_W +: PRIV_W]), 32'(m_priv[i]));
            for (i = 0; i < hold; i++) begin
                @(posedge clk);
                #1;
            end
            req = 1'b0;
            cmd = CSR_CMD_NONE;
            cnt = 0;
            while (ack && cnt < 50) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (ack) begin
                errors++;
                $display("Timeout: ack from hart %0d stayed high after req fell", h);
                end_run();
            end
        end
    endtask

    task automatic pulse_instret(input int h, input int n);
        @(posedge clk);
        #1;
        instret_incr[h] = 1'b1;
        repeat (n) @(posedge clk);                  // n sampled pulses
        #1;
        instret_incr[h] = 1'b0;
        m_instret[h] = m_instret[h] + CNT_W'(n);
    endtask

    initial begin
        int h;
        int k;
        req          = 1'b0;
        hart_sel     = '0;
        cmd          = CSR_CMD_NONE;
        address      = '0;
        writedata    = '0;
        instret_incr = '0;
        rst_n        = 1'b0;
        for (h = 0; h < NUM_HARTS; h++) begin
            m_mstatus[h] = '0;
            m_priv[h]    = PRIV_MACHINE;
            m_instret[h] = '0;
            m_misa_a[h]  = 1'b0;
            for (k = 0; k < 32; k++)
                m_reg[h][k] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (h = 0; h < NUM_HARTS; h++) begin       // Reset state and identity
            run_cmd(h, CSR_CMD_READ, CSR_ADDR_MVENDORID, '0);
            run_cmd(h, CSR_CMD_READ, CSR_ADDR_MARCHID, '0);
            run_cmd(h, CSR_CMD_READ, CSR_ADDR_MIMPID, '0);
            run_cmd(h, CSR_CMD_READ, CSR_ADDR_MHARTID, '0);
            run_cmd(h, CSR_CMD_READ, CSR_ADDR_MCURPRIV, '0);
            run_cmd(h, CSR_CMD_READ, CSR_ADDR_MSTATUS, '0);
        end

        for (h = 0; h < NUM_HARTS; h++)             // Per-hart storage
            for (k = 0; k < 10; k++)
                run_cmd(h, CSR_CMD_WRITE, PLAIN_ADDR[k], random_word() & 32'hFFFF_FFFC);
        for (h = 0; h < NUM_HARTS; h++)
            for (k = 0; k < 10; k++)
                run_cmd(h, CSR_CMD_READ, PLAIN_ADDR[k], '0);
        run_cmd(0, CSR_CMD_READ_WRITE, CSR_ADDR_MSCRATCH, random_word());
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_MSCRATCH, '0);

        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_MTVEC, 32'h0000_1001);   // Misaligned, dropped
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_MTVEC, '0);
        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_MEPC, 32'h0000_2002);
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_MEPC, '0);
        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_SEPC, 32'h0000_3003);
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_SEPC, '0);
        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_MSTATUS, 32'hFFFF_FFFF);
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_MSTATUS, '0);
        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_MSTATUS, 32'h0000_1088);  // mpp of 2
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_MSTATUS, '0);
        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_MISA, 32'hFFFF_FFFF);
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_MISA, '0);
        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_MISA, 32'h0000_0000);
        run_cmd(0, CSR_CMD_READ, CSR_ADDR_MISA, '0);

        run_cmd(2, CSR_CMD_WRITE, CSR_ADDR_MSTATUS, 32'h0000_0880);  // mpp S, mpie set
        run_cmd(2, CSR_CMD_MRET, '0, '0);
        run_cmd(2, CSR_CMD_READ, CSR_ADDR_MCURPRIV, '0);
        run_cmd(2, CSR_CMD_READ, CSR_ADDR_MSTATUS, '0);
        run_cmd(2, CSR_CMD_WRITE, CSR_ADDR_SSCRATCH, random_word());
        run_cmd(2, CSR_CMD_READ, CSR_ADDR_SSCRATCH, '0);
        run_cmd(2, CSR_CMD_WRITE, CSR_ADDR_MVENDORID, 32'h1234_5678);
        run_cmd(2, CSR_CMD_READ, CSR_ADDR_MHARTID, '0);
        run_cmd(2, CSR_CMD_READ, 12'h7C0, '0);
        run_cmd(0, CSR_CMD_WRITE, CSR_ADDR_MHARTID, 32'h0000_0007);  // Read-only quarter
        run_cmd(0, CSR_CMD_WRITE, 12'h7C0, 32'h0000_0001);
        run_cmd(0, CSR_CMD_READ, 12'h7C0, '0);

        pulse_instret(1, 7);                        // Counters
        run_cmd(1, CSR_CMD_READ, CSR_ADDR_INSTRET, '0);
        pulse_instret(1, 5);
        run_cmd(1, CSR_CMD_READ, CSR_ADDR_INSTRET, '0);
        run_cmd(1, CSR_CMD_WRITE, CSR_ADDR_INSTRET, 32'hFFFF_FFF8);
        pulse_instret(1, 12);                       // Carries into the high word
        run_cmd(1, CSR_CMD_READ, CSR_ADDR_INSTRET, '0);
        run_cmd(1, CSR_CMD_READ, CSR_ADDR_INSTRETH, '0);

        run_cmd(3, CSR_CMD_WRITE, CSR_ADDR_MSTATUS, 32'h0000_0800);  // Back-pressure
        run_cmd(3, CSR_CMD_MRET, '0, '0, 30);
        run_cmd(3, CSR_CMD_READ, CSR_ADDR_MCURPRIV, '0);    // Second MRET would give user
        run_cmd(3, CSR_CMD_READ, CSR_ADDR_SSCRATCH, '0);

        end_run();
    end

endmodule

`default_nettype wire

/* src.f */
hw/csr_pkg.sv
hw/csr_dispatch.sv
hw/csr_file.sv
hw/csr_collect.sv
hw/csr_cluster.sv
testbench/csr_cluster_asserts.sv
testbench/tb_csr_cluster.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f src.f --top-module tb_csr_cluster -o sim_tb \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
